/* rtl/packet_q_pkg.sv */
package packet_q_pkg;

    // --------------------
    // Fixed widths
    // --------------------
    localparam int DATA_BYTES = 8;
    localparam int DATA_WID   = 64;
    localparam int MTY_WID    = 3;
    localparam int SIZE_WID   = 16;

    // Pointer fields sized for a pool of up to 256 buffers
    localparam int PTR_WID_MAX = 8;

    // --------------------
    // Types
    // --------------------
    // One beat on the packet ports and in the data RAM
    typedef struct packed {
        logic [DATA_WID-1:0] data;
        logic                eop;
        // Empty upper bytes, only meaningful with eop
        logic [MTY_WID-1:0]  mty;
    } pkt_beat_t;

    // Stored packet that points at the head of its buffer chain
    typedef struct packed {
        logic [PTR_WID_MAX-1:0] head_ptr;
        logic [SIZE_WID-1:0]    size;
        logic                   err;
    } pkt_desc_t;

endpackage : packet_q_pkg

/* rtl/sdp_ram.sv */
`timescale 1ns/1ns

module sdp_ram #(
    parameter int  DEPTH    = 64,
    parameter int  WIDTH    = 8,
    localparam int ADDR_WID = $clog2(DEPTH)
) (
    input  logic                clk,
    input  logic                wr_en,
    input  logic [ADDR_WID-1:0] wr_addr,
    input  logic [WIDTH-1:0]    wr_data,
    input  logic [ADDR_WID-1:0] rd_addr,
    output logic [WIDTH-1:0]    rd_data
);

    logic [WIDTH-1:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read data one cycle after the address
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule : sdp_ram

/* rtl/buffer_alloc.sv */
`timescale 1ns/1ns

module buffer_alloc #(
    parameter int  NUM_BUFFERS = 16,
    localparam int PTR_WID     = $clog2(NUM_BUFFERS)
) (
    input  logic               clk,
    input  logic               reset,
    output logic               init_done,
    output logic               free_valid,
    output logic [PTR_WID-1:0] free_ptr,
    input  logic               alloc_take,
    input  logic               recycle_req,
    input  logic [PTR_WID-1:0] recycle_ptr
);

    localparam int CNT_WID = $clog2(NUM_BUFFERS + 1);

    logic [PTR_WID-1:0] free_list [NUM_BUFFERS];
    logic [PTR_WID-1:0] head;
    logic [PTR_WID-1:0] tail;
    logic [CNT_WID-1:0] count;

    logic               sweep_active;
    logic [PTR_WID-1:0] sweep_ptr;

    logic               push;
    logic [PTR_WID-1:0] push_ptr;
    logic               pop;

    function automatic logic [PTR_WID-1:0] next_idx(input logic [PTR_WID-1:0] idx);
        return (idx == PTR_WID'(NUM_BUFFERS - 1)) ? '0 : idx + 1'b1;
    endfunction

    // --------------------
    // Initial sweep
    // --------------------
    // Every pointer enters the list once, one per cycle
    always_ff @(posedge clk) begin
        if (reset) begin
            sweep_active <= 1'b1;
            sweep_ptr    <= '0;
            init_done    <= 1'b0;
        end else if (sweep_active) begin
            sweep_ptr <= sweep_ptr + 1'b1;
            if (sweep_ptr == PTR_WID'(NUM_BUFFERS - 1)) begin
                sweep_active <= 1'b0;
                init_done    <= 1'b1;
            end
        end
    end

    // --------------------
    // Free list
    // --------------------
    assign push     = sweep_active || recycle_req;
    assign push_ptr = sweep_active ? sweep_ptr : recycle_ptr;
    assign pop      = alloc_take && free_valid;

    assign free_valid = init_done && (count != '0);
    assign free_ptr   = free_list[head];

    always_ff @(posedge clk) begin
        if (push) begin
            free_list[tail] <= push_ptr;
        end
    end

    // Take and recycle may land together
    always_ff @(posedge clk) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (push) begin
                tail <= next_idx(tail);
            end
            if (pop) begin
                head <= next_idx(head);
            end
            count <= count + CNT_WID'(push) - CNT_WID'(pop);
        end
    end

endmodule : buffer_alloc

/* rtl/desc_fifo.sv */
`timescale 1ns/1ns

module desc_fifo #(
    parameter int DESC_DEPTH = 8
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    push,
    input  packet_q_pkg::pkt_desc_t push_desc,
    output logic                    full,
    output logic                    valid,
    output packet_q_pkg::pkt_desc_t pop_desc,
    input  logic                    pop
);

    import packet_q_pkg::*;

    localparam int IDX_WID = $clog2(DESC_DEPTH);
    localparam int CNT_WID = $clog2(DESC_DEPTH + 1);

    pkt_desc_t          ring [DESC_DEPTH];
    logic [IDX_WID-1:0] wr_idx;
    logic [IDX_WID-1:0] rd_idx;
    logic [CNT_WID-1:0] count;
    logic               do_push;
    logic               do_pop;

    assign full     = (count == CNT_WID'(DESC_DEPTH));
    assign valid    = (count != '0);
    assign pop_desc = ring[rd_idx];

    assign do_push = push && !full;
    assign do_pop  = pop && valid;

    always_ff @(posedge clk) begin
        if (do_push) begin
            ring[wr_idx] <= push_desc;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_idx <= (wr_idx == IDX_WID'(DESC_DEPTH - 1)) ? '0 : wr_idx + 1'b1;
            end
            if (do_pop) begin
                rd_idx <= (rd_idx == IDX_WID'(DESC_DEPTH - 1)) ? '0 : rd_idx + 1'b1;
            end
            count <= count + CNT_WID'(do_push) - CNT_WID'(do_pop);
        end
    end

endmodule : desc_fifo

/* rtl/packet_scatter.sv */
`timescale 1ns/1ns

module packet_scatter #(
    parameter int  BUFFER_WORDS  = 4,
    parameter int  MAX_PKT_BYTES = 96,
    parameter int  PTR_WID       = 4,
    localparam int OFF_WID       = $clog2(BUFFER_WORDS),
    localparam int ADDR_WID      = PTR_WID + OFF_WID
) (
    input  logic                    clk,
    input  logic                    reset,
    input  packet_q_pkg::pkt_beat_t in_beat,
    input  logic                    in_err,
    input  logic                    in_valid,
    output logic                    in_ready,
    input  logic                    free_valid,
    input  logic [PTR_WID-1:0]      free_ptr,
    output logic                    alloc_take,
    output logic                    data_wr_en,
    output logic [ADDR_WID-1:0]     data_wr_addr,
    output packet_q_pkg::pkt_beat_t data_wr_data,
    output logic                    link_wr_en,
    output logic [PTR_WID-1:0]      link_wr_addr,
    output logic [PTR_WID-1:0]      link_wr_data,
    input  logic                    desc_in_full,
    output logic                    desc_in_valid,
    output packet_q_pkg::pkt_desc_t desc_in
);

    import packet_q_pkg::*;

    // Write position in the current packet
    logic [OFF_WID-1:0]  offset;
    logic [PTR_WID-1:0]  cur_ptr;
    logic [PTR_WID-1:0]  head_ptr;
    logic [SIZE_WID-1:0] byte_cnt;
    logic                discard;

    // Last stored word that truncation rewrites with eop
    logic [DATA_WID-1:0] last_data;
    logic [ADDR_WID-1:0] last_addr;

    logic [SIZE_WID-1:0] beat_bytes;
    logic [SIZE_WID-1:0] sum_bytes;
    logic                overflow;
    logic                need_buf;
    logic                accept;
    logic                store;
    logic [PTR_WID-1:0]  wr_ptr;

    // --------------------
    // Beat accounting
    // --------------------
    assign beat_bytes = in_beat.eop ? SIZE_WID'(DATA_BYTES - int'(in_beat.mty))
                                    : SIZE_WID'(DATA_BYTES);
    assign sum_bytes  = byte_cnt + beat_bytes;
    assign overflow   = !discard && (sum_bytes > SIZE_WID'(MAX_PKT_BYTES));
    assign need_buf   = (offset == '0) && !discard && !overflow;

    // Stall for a free buffer, or at eop for a descriptor slot
    assign in_ready = !(need_buf && !free_valid)
                   && !(in_beat.eop && (desc_in_full || desc_in_valid));

    assign accept = in_valid && in_ready;
    assign store  = accept && !discard && !overflow;
    assign wr_ptr = need_buf ? free_ptr : cur_ptr;

    assign alloc_take = store && need_buf;

    // Old-to-new link when a packet runs into a fresh buffer
    assign link_wr_en   = alloc_take && (byte_cnt != '0);
    assign link_wr_addr = cur_ptr;
    assign link_wr_data = free_ptr;

    always_comb begin
        data_wr_en   = store || (accept && overflow);
        data_wr_addr = {wr_ptr, offset};
        data_wr_data = in_beat;
        if (overflow) begin
            // Close the stored part of the packet
            data_wr_addr = last_addr;
            data_wr_data = '{data: last_data, eop: 1'b1, mty: MTY_WID'(0)};
        end
    end

    // --------------------
    // State
    // --------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            offset        <= '0;
            byte_cnt      <= '0;
            discard       <= 1'b0;
            desc_in_valid <= 1'b0;
        end else begin
            desc_in_valid <= accept && in_beat.eop;
            if (accept && in_beat.eop) begin
                offset   <= '0;
                byte_cnt <= '0;
                discard  <= 1'b0;
            end else if (store) begin
                offset   <= offset + 1'b1;
                byte_cnt <= sum_bytes;
            end else if (accept && overflow) begin
                discard <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (alloc_take) begin
            cur_ptr <= free_ptr;
            if (byte_cnt == '0) begin
                head_ptr <= free_ptr;
            end
        end
        if (store) begin
            last_data <= in_beat.data;
            last_addr <= data_wr_addr;
        end
        if (accept && in_beat.eop) begin
            desc_in.head_ptr <= PTR_WID_MAX'((byte_cnt == '0) ? free_ptr : head_ptr);
            desc_in.size     <= store ? sum_bytes : byte_cnt;
            // Beat not stored means the packet was cut short
            desc_in.err      <= in_err || !store;
        end
    end

endmodule : packet_scatter

/* rtl/packet_gather.sv */
`timescale 1ns/1ns

module packet_gather #(
    parameter int  BUFFER_WORDS = 4,
    parameter bit  DROP_ERRORED = 1,
    parameter int  PTR_WID      = 4,
    localparam int OFF_WID      = $clog2(BUFFER_WORDS),
    localparam int ADDR_WID     = PTR_WID + OFF_WID
) (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    desc_out_valid,
    input  packet_q_pkg::pkt_desc_t desc_out,
    output logic                    desc_out_pop,
    output logic [ADDR_WID-1:0]     data_rd_addr,
    input  packet_q_pkg::pkt_beat_t data_rd_data,
    output logic [PTR_WID-1:0]      link_rd_addr,
    input  logic [PTR_WID-1:0]      link_rd_data,
    output packet_q_pkg::pkt_beat_t out_beat,
    output logic                    out_err,
    output logic                    out_valid,
    input  logic                    out_ready,
    output logic                    recycle_req,
    output logic [PTR_WID-1:0]      recycle_ptr
);

    typedef enum logic [1:0] {
        s_idle,
        s_walk,
        s_link
    } state_t;

    state_t             state;
    state_t             state_nxt;
    logic [PTR_WID-1:0] cur_ptr;
    logic [PTR_WID-1:0] ptr_nxt;
    logic [OFF_WID-1:0] offset;
    logic [OFF_WID-1:0] offset_nxt;
    logic               pkt_err;
    logic               drop;
    logic               take_word;
    logic               buf_end;

    // Word leaves the RAM once the output register frees up, or at once when dropping
    assign take_word = (state == s_walk) && (drop || !out_valid || out_ready);
    assign buf_end   = take_word
                    && (data_rd_data.eop || offset == OFF_WID'(BUFFER_WORDS - 1));

    assign desc_out_pop = (state == s_idle) && desc_out_valid;
    assign recycle_req  = buf_end;
    assign recycle_ptr  = cur_ptr;
    assign link_rd_addr = cur_ptr;

    // --------------------
    // Chain walk
    // --------------------
    always_comb begin
        state_nxt  = state;
        ptr_nxt    = cur_ptr;
        offset_nxt = offset;
        case (state)
            s_idle: begin
                if (desc_out_valid) begin
                    state_nxt  = s_walk;
                    ptr_nxt    = desc_out.head_ptr[PTR_WID-1:0];
                    offset_nxt = '0;
                end
            end
            s_walk: begin
                if (buf_end) begin
                    state_nxt = data_rd_data.eop ? s_idle : s_link;
                end else if (take_word) begin
                    offset_nxt = offset + 1'b1;
                end
            end
            s_link: begin
                // Next pointer has been read by now
                state_nxt  = s_walk;
                ptr_nxt    = link_rd_data;
                offset_nxt = '0;
            end
            default: begin
                state_nxt = s_idle;
            end
        endcase
    end

    // Address the next word so that one is ready every cycle
    assign data_rd_addr = {ptr_nxt, offset_nxt};

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= s_idle;
            out_valid <= 1'b0;
        end else begin
            state <= state_nxt;
            if (take_word && !drop) begin
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        cur_ptr <= ptr_nxt;
        offset  <= offset_nxt;
        if (desc_out_pop) begin
            pkt_err <= desc_out.err;
            drop    <= DROP_ERRORED && desc_out.err;
        end
        if (take_word && !drop) begin
            out_beat <= data_rd_data;
            out_err  <= data_rd_data.eop && pkt_err;
        end
    end

endmodule : packet_gather

/* rtl/packet_q_core.sv */
`timescale 1ns/1ns

module packet_q_core #(
    parameter int  NUM_BUFFERS   = 16,
    parameter int  BUFFER_WORDS  = 4,
    parameter int  MAX_PKT_BYTES = 96,
    parameter bit  DROP_ERRORED  = 1,
    localparam int PTR_WID       = $clog2(NUM_BUFFERS),
    localparam int ADDR_WID      = PTR_WID + $clog2(BUFFER_WORDS)
) (
    input  logic                    clk,
    input  logic                    reset,
    output logic                    init_done,
    // Packet ports
    input  packet_q_pkg::pkt_beat_t in_beat,
    input  logic                    in_err,
    input  logic                    in_valid,
    output logic                    in_ready,
    output packet_q_pkg::pkt_beat_t out_beat,
    output logic                    out_err,
    output logic                    out_valid,
    input  logic                    out_ready,
    // Data and link RAMs
    output logic                    data_wr_en,
    output logic [ADDR_WID-1:0]     data_wr_addr,
    output packet_q_pkg::pkt_beat_t data_wr_data,
    output logic [ADDR_WID-1:0]     data_rd_addr,
    input  packet_q_pkg::pkt_beat_t data_rd_data,
    output logic                    link_wr_en,
    output logic [PTR_WID-1:0]      link_wr_addr,
    output logic [PTR_WID-1:0]      link_wr_data,
    output logic [PTR_WID-1:0]      link_rd_addr,
    input  logic [PTR_WID-1:0]      link_rd_data,
    // Descriptor queue
    input  logic                    desc_in_full,
    output logic                    desc_in_valid,
    output packet_q_pkg::pkt_desc_t desc_in,
    input  logic                    desc_out_valid,
    input  packet_q_pkg::pkt_desc_t desc_out,
    output logic                    desc_out_pop
);

    logic               free_valid;
    logic [PTR_WID-1:0] free_ptr;
    logic               alloc_take;
    logic               recycle_req;
    logic [PTR_WID-1:0] recycle_ptr;

    buffer_alloc #(
        .NUM_BUFFERS ( NUM_BUFFERS )
    ) i_buffer_alloc (
        .clk, .reset, .init_done, .free_valid, .free_ptr,
        .alloc_take, .recycle_req, .recycle_ptr
    );

    // Input side fills buffers from the free list
    packet_scatter #(
        .BUFFER_WORDS  ( BUFFER_WORDS ),
        .MAX_PKT_BYTES ( MAX_PKT_BYTES ),
        .PTR_WID       ( PTR_WID )
    ) i_packet_scatter (
        .clk, .reset, .in_beat, .in_err, .in_valid, .in_ready,
        .free_valid, .free_ptr, .alloc_take,
        .data_wr_en, .data_wr_addr, .data_wr_data,
        .link_wr_en, .link_wr_addr, .link_wr_data,
        .desc_in_full, .desc_in_valid, .desc_in
    );

    // Output side hands buffers back once read
    packet_gather #(
        .BUFFER_WORDS ( BUFFER_WORDS ),
        .DROP_ERRORED ( DROP_ERRORED ),
        .PTR_WID      ( PTR_WID )
    ) i_packet_gather (
        .clk, .reset, .desc_out_valid, .desc_out, .desc_out_pop,
        .data_rd_addr, .data_rd_data, .link_rd_addr, .link_rd_data,
        .out_beat, .out_err, .out_valid, .out_ready,
        .recycle_req, .recycle_ptr
    );

endmodule : packet_q_core

/* rtl/packet_q.sv */
`timescale 1ns/1ns

module packet_q #(
    parameter int NUM_BUFFERS   = 16,
    parameter int BUFFER_WORDS  = 4,
    parameter int MAX_PKT_BYTES = 96,
    parameter int DESC_DEPTH    = 8,
    parameter bit DROP_ERRORED  = 1
) (
    input  logic                    clk,
    input  logic                    reset,
    output logic                    init_done,
    input  packet_q_pkg::pkt_beat_t in_beat,
    input  logic                    in_err,
    input  logic                    in_valid,
    output logic                    in_ready,
    output packet_q_pkg::pkt_beat_t out_beat,
    output logic                    out_err,
    output logic                    out_valid,
    input  logic                    out_ready
);

    import packet_q_pkg::*;

    localparam int PTR_WID  = $clog2(NUM_BUFFERS);
    localparam int ADDR_WID = PTR_WID + $clog2(BUFFER_WORDS);

    // --------------------
    // RAM and queue nets
    // --------------------
    logic                data_wr_en;
    logic [ADDR_WID-1:0] data_wr_addr;
    pkt_beat_t           data_wr_data;
    logic [ADDR_WID-1:0] data_rd_addr;
    pkt_beat_t           data_rd_data;
    logic                link_wr_en;
    logic [PTR_WID-1:0]  link_wr_addr;
    logic [PTR_WID-1:0]  link_wr_data;
    logic [PTR_WID-1:0]  link_rd_addr;
    logic [PTR_WID-1:0]  link_rd_data;
    logic                desc_in_full;
    logic                desc_in_valid;
    pkt_desc_t           desc_in;
    logic                desc_out_valid;
    pkt_desc_t           desc_out;
    logic                desc_out_pop;

    packet_q_core #(
        .NUM_BUFFERS   ( NUM_BUFFERS ),
        .BUFFER_WORDS  ( BUFFER_WORDS ),
        .MAX_PKT_BYTES ( MAX_PKT_BYTES ),
        .DROP_ERRORED  ( DROP_ERRORED )
    ) i_packet_q_core (
        .clk, .reset, .init_done,
        .in_beat, .in_err, .in_valid, .in_ready,
        .out_beat, .out_err, .out_valid, .out_ready,
        .data_wr_en, .data_wr_addr, .data_wr_data, .data_rd_addr, .data_rd_data,
        .link_wr_en, .link_wr_addr, .link_wr_data, .link_rd_addr, .link_rd_data,
        .desc_in_full, .desc_in_valid, .desc_in,
        .desc_out_valid, .desc_out, .desc_out_pop
    );

    // Packet words addressed by buffer and word offset
    sdp_ram #(
        .DEPTH ( NUM_BUFFERS * BUFFER_WORDS ),
        .WIDTH ( $bits(pkt_beat_t) )
    ) i_data_ram (
        .clk, .wr_en(data_wr_en), .wr_addr(data_wr_addr), .wr_data(data_wr_data),
        .rd_addr(data_rd_addr), .rd_data(data_rd_data)
    );

    // Next pointer per buffer
    sdp_ram #(
        .DEPTH ( NUM_BUFFERS ),
        .WIDTH ( PTR_WID )
    ) i_link_ram (
        .clk, .wr_en(link_wr_en), .wr_addr(link_wr_addr), .wr_data(link_wr_data),
        .rd_addr(link_rd_addr), .rd_data(link_rd_data)
    );

    desc_fifo #(
        .DESC_DEPTH ( DESC_DEPTH )
    ) i_desc_fifo (
        .clk, .reset,
        .push(desc_in_valid), .push_desc(desc_in), .full(desc_in_full),
        .valid(desc_out_valid), .pop_desc(desc_out), .pop(desc_out_pop)
    );

endmodule : packet_q

/* verification/packet_q_tb_model.svh */
`ifndef PACKET_Q_TB_MODEL_SVH
`define PACKET_Q_TB_MODEL_SVH

// Largest packet the queue stores whole
localparam int MAX_BYTES = 96;

// Beats still owed by the DUT in arrival order
pkt_beat_t exp_q[$];
int        exp_pkts = 0;
int        got_pkts = 0;
int        errors = 0;
string     test_name = "none";

// --------------------
// Reference model
// --------------------
task automatic record_packet(input pkt_beat_t beats[$], input int bytes, input bit err);
    bit dropped;
    // Anything past the byte limit is cut off and the packet counts as errored
    dropped = err || (bytes > MAX_BYTES);
    if (!dropped) begin
        foreach (beats[i]) begin
            exp_q.push_back(beats[i]);
        end
        exp_pkts++;
    end
endtask

// --------------------
// Compare tasks
// --------------------
task automatic check_beat(input pkt_beat_t exp, input pkt_beat_t act);
    if (act !== exp) begin
        $display("CHECK FAILED %s beat: expected %h actual %h", test_name, exp, act);
        errors++;
    end
endtask

task automatic check_count(input string what, input int exp, input int act);
    if (act != exp) begin
        $display("CHECK FAILED %s %s: expected %0d actual %0d", test_name, what, exp, act);
        errors++;
    end
endtask

`endif

/* verification/packet_q_tb.sv */
`timescale 1ns/1ns

module packet_q_tb;

    import packet_q_pkg::*;

    localparam int TIMEOUT = 2000;

    logic      clk;
    logic      reset;
    logic      init_done;
    pkt_beat_t in_beat;
    logic      in_err;
    logic      in_valid;
    logic      in_ready;
    pkt_beat_t out_beat;
    logic      out_err;
    logic      out_valid;
    logic      out_ready;

    bit hold_out;
    bit sending;
    int tests_run;
    int tests_failed;
    int test_err0;

    `include "packet_q_tb_model.svh"

    packet_q dut_i (.*);

    always #2 clk = ~clk;

    // Output monitor that picks out_ready and checks each transfer
    always @(negedge clk) begin
        out_ready = !hold_out && ($urandom % 4 != 0);
        if (out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("Output beat %h arrived with no packet expected", out_beat);
                errors++;
            end else begin
                check_beat(exp_q.pop_front(), out_beat);
                check_count("out_err", 0, int'(out_err));
                if (out_beat.eop) got_pkts++;
            end
        end
    end

    task automatic finish_run();
        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("TESTBENCH PASSED");
        end else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    endtask

    task automatic fail_timeout(input string what);
        $display("Timeout in test %s: %s", test_name, what);
        errors++;
        finish_run();
    endtask

    task automatic start_test(input string name);
        test_name = name;
        test_err0 = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != test_err0) tests_failed++;
        $display("test %s: %s", test_name, (errors == test_err0) ? "ok" : "failed");
    endtask

    // --------------------
    // Stimulus
    // --------------------
    task automatic send_packet(input int bytes, input bit err);
        pkt_beat_t beats[$];
        pkt_beat_t beat;
        int        left;
        int        cycles;
        left = bytes;
        while (left > 0) begin
            beat.data = {$urandom, $urandom};
            beat.eop  = (left <= DATA_BYTES);
            beat.mty  = beat.eop ? MTY_WID'(DATA_BYTES - left) : '0;
            // Empty upper bytes are zero
            for (int b = DATA_BYTES - int'(beat.mty); b < DATA_BYTES; b++) begin
                beat.data[8*b +: 8] = 8'h00;
            end
            beats.push_back(beat);
            left -= DATA_BYTES;
        end
        foreach (beats[i]) begin
            @(negedge clk);
            in_valid = 1'b0;
            repeat ($urandom % 3) @(negedge clk);
            in_beat  = beats[i];
            in_err   = err;
            in_valid = 1'b1;
            cycles   = 0;
            #1;
            while (!in_ready) begin
                cycles++;
                if (cycles > TIMEOUT) fail_timeout("input beat was never accepted");
                @(negedge clk);
                #1;
            end
        end
        @(negedge clk);
        in_valid = 1'b0;
        record_packet(beats, bytes, err);
    endtask

    task automatic send_random_packets(input int count, input int min_b, input int max_b,
                                       input bit with_err);
        for (int n = 0; n < count; n++) begin
            send_packet(min_b + int'($urandom % (max_b - min_b + 1)),
                        with_err && ($urandom % 6 == 0));
        end
    endtask

    task automatic drain_output();
        int cycles;
        cycles = 0;
        while (exp_q.size() != 0 || out_valid) begin
            @(negedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) fail_timeout("output did not drain");
        end
    endtask

    initial begin
        int cycles;
        int stall;
        void'($urandom(32'h865bb9ea));
        clk       = 1'b0;
        reset     = 1'b1;
        in_beat   = '0;
        in_err    = 1'b0;
        in_valid  = 1'b0;
        out_ready = 1'b0;
        hold_out  = 1'b0;
        repeat (16) @(negedge clk);
        reset = 1'b0;

        start_test("init");
        cycles = 0;
        while (!init_done) begin
            @(negedge clk);
            #1;
            if (!init_done) check_count("in_ready", 0, int'(in_ready));
            cycles++;
            if (cycles > TIMEOUT) fail_timeout("init_done never rose");
        end
        end_test();

        start_test("single_buffer");
        send_random_packets(30, 1, 32, 1'b0);
        drain_output();
        end_test();

        start_test("chained");
        send_random_packets(30, 33, 96, 1'b0);
        drain_output();
        end_test();

        start_test("errored");
        send_random_packets(40, 1, 120, 1'b1);
        drain_output();
        end_test();

        // Output blocked until the input has stalled
        start_test("stall");
        hold_out = 1'b1;
        sending  = 1'b1;
        fork
            begin
                send_random_packets(20, 1, 96, 1'b0);
                sending = 1'b0;
            end
        join_none
        stall  = 0;
        cycles = 0;
        while (stall < 20) begin
            @(negedge clk);
            #1;
            stall = (in_valid && !in_ready) ? stall + 1 : 0;
            cycles++;
            if (cycles > TIMEOUT) fail_timeout("input never stalled");
        end
        hold_out = 1'b0;
        cycles   = 0;
        while (sending) begin
            @(negedge clk);
            #1;
            cycles++;
            if (cycles > TIMEOUT) fail_timeout("stalled packets were not all sent");
        end
        drain_output();
        end_test();

        start_test("count");
        check_count("packets", exp_pkts, got_pkts);
        end_test();

        finish_run();
    end

endmodule : packet_q_tb

/* verilog.f */
+incdir+verification
rtl/packet_q_pkg.sv
rtl/sdp_ram.sv
rtl/buffer_alloc.sv
rtl/desc_fifo.sv
rtl/packet_scatter.sv
rtl/packet_gather.sv
rtl/packet_q_core.sv
rtl/packet_q.sv
verification/packet_q_tb.sv

/* run.sh */
#!/bin/sh
# Build the packet queue testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f verilog.f --top-module packet_q_tb -o packet_q_tb
./obj_dir/packet_q_tb > sim.log 2>&1
cat sim.log

# The log decides pass or fail
if grep -q "TESTBENCH PASSED" sim.log; then
    exit 0
fi
exit 1
